// ==== fcore_slice.f ====
logic/fcore_isa_pkg.sv
logic/register_file.sv
logic/operand_fetch.sv
logic/bitmanip_unit.sv
logic/logic_unit.sv
logic/result_writeback.sv
logic/fcore_slice.sv
tb/fcore_slice_tb.sv

// ==== tb/fcore_slice_tb.sv ====
/*
 * Directed testbench for the control core execution slice.
 * Issues instructions, keeps a register model and checks every reported result.
 */
`timescale 1ns/100ps

module fcore_slice_tb;
    import fcore_isa_pkg::*;

    localparam int result_timeout = 20;
    localparam int busy_timeout   = 10;

    logic      clock;
    logic      rst_n;
    logic      instr_valid;
    op_t       instr_op;
    reg_addr_t instr_dest;
    reg_addr_t instr_src_a;
    reg_addr_t instr_src_b;
    reg_addr_t instr_src_c;
    data_t     instr_imm;
    logic      busy;
    logic      result_valid;
    reg_addr_t result_dest;
    data_t     result_data;

    data_t     model_regs [reg_count];
    reg_addr_t exp_dest_q [$];
    data_t     exp_data_q [$];
    reg_addr_t got_dest_q [$];
    data_t     got_data_q [$];
    int        seed;

    fcore_slice dut (
        .clock, .rst_n,
        .instr_valid, .instr_op, .instr_dest,
        .instr_src_a, .instr_src_b, .instr_src_c, .instr_imm,
        .busy, .result_valid, .result_dest, .result_data
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Results are captured on the falling edge, half a cycle after they change
    always @(negedge clock) begin
        if (rst_n && result_valid) begin
            got_dest_q.push_back(result_dest);
            got_data_q.push_back(result_data);
        end
    end

    // Expected value of an instruction, worked out from the instruction set rules
    function automatic data_t expected_value(op_t op, data_t a, data_t b, data_t c, data_t imm);
        int    pos;
        data_t r;
        pos = b % 32;
        r   = '0;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_ldi:  r = imm;
            op_bext: r = (a >> pos) & 32'd1;
            op_bset: r = (a & ~(data_t'(1) << pos)) | (data_t'(c[0]) << pos);
            op_popcnt: begin
                for (int i = 0; i < data_width; i++) begin
                    r = r + a[i];
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic bit produces_result(op_t op);
        return op inside {op_add, op_sub, op_popcnt, op_and, op_bext,
                          op_or, op_bset, op_xor, op_ldi};
    endfunction

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, data_t expected, data_t actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_dest(string name, reg_addr_t expected, reg_addr_t actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("error: %s expected %b actual %b", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Holds the strobe for one cycle; a popcount in flight delays the next issue
    task automatic send_instr(op_t op, reg_addr_t dest, reg_addr_t sa, reg_addr_t sb,
                              reg_addr_t sc, data_t imm);
        int waited;
        waited = 0;
        @(negedge clock);
        instr_valid = 1'b0;
        while (busy) begin
            if (waited >= busy_timeout) begin
                $display("busy stayed high for more than %0d cycles", busy_timeout);
                stop_on_failure();
            end
            @(negedge clock);
            waited++;
        end
        instr_op    = op;
        instr_dest  = dest;
        instr_src_a = sa;
        instr_src_b = sb;
        instr_src_c = sc;
        instr_imm   = imm;
        instr_valid = 1'b1;
        if (produces_result(op)) begin
            exp_dest_q.push_back(dest);
            exp_data_q.push_back(expected_value(op, model_regs[sa], model_regs[sb],
                                                model_regs[sc], imm));
        end
    endtask

    task automatic stop_driving();
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    // Results must come back in issue order, and each one updates the model.
    // The captured queues are read on the rising edge, away from the capture.
    task automatic collect_results(string name);
        int        waited;
        reg_addr_t dest;
        data_t     data;
        while (exp_dest_q.size() > 0) begin
            waited = 0;
            while (got_dest_q.size() == 0) begin
                if (waited >= result_timeout) begin
                    $display("no result for %s within %0d cycles", name, result_timeout);
                    stop_on_failure();
                end
                @(posedge clock);
                waited++;
            end
            dest = exp_dest_q.pop_front();
            data = exp_data_q.pop_front();
            check_dest(name, dest, got_dest_q.pop_front());
            check_data(name, data, got_data_q.pop_front());
            model_regs[dest] = data;
        end
    endtask

    task automatic expect_quiet(string name, int cycles);
        repeat (cycles) @(posedge clock);
        if (got_dest_q.size() != 0) begin
            $display("%s produced a result that no instruction should have", name);
            stop_on_failure();
        end
    endtask

    task automatic exec_instr(op_t op, reg_addr_t dest, reg_addr_t sa, reg_addr_t sb,
                              reg_addr_t sc, string name);
        send_instr(op, dest, sa, sb, sc, '0);
        stop_driving();
        collect_results(name);
    endtask

    task automatic load_reg(reg_addr_t r, data_t value);
        send_instr(op_ldi, r, 4'd0, 4'd0, 4'd0, value);
        stop_driving();
        collect_results("ldi");
    endtask

    task automatic test_reset_state();
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset result_valid", 1'b0, result_valid);
        send_instr(op_nop, 4'd1, 4'd2, 4'd3, 4'd4, 32'hdead_beef);
        stop_driving();
        expect_quiet("nop", 8);
    endtask

    task automatic test_logic_ops();
        for (int r = 1; r < 5; r++) begin
            load_reg(reg_addr_t'(r), data_t'($random(seed)));
        end
        exec_instr(op_add, 4'd5, 4'd1, 4'd2, 4'd0, "add");
        exec_instr(op_sub, 4'd6, 4'd5, 4'd3, 4'd0, "sub");
        exec_instr(op_and, 4'd7, 4'd6, 4'd4, 4'd0, "and");
        exec_instr(op_or, 4'd8, 4'd1, 4'd7, 4'd0, "or");
        exec_instr(op_xor, 4'd9, 4'd8, 4'd2, 4'd0, "xor");
        // Wrap around in both directions
        load_reg(4'd11, 32'hffff_ffff);
        load_reg(4'd12, 32'd1);
        exec_instr(op_add, 4'd13, 4'd11, 4'd12, 4'd0, "add wrap");
        exec_instr(op_sub, 4'd14, 4'd13, 4'd12, 4'd0, "sub wrap");
    endtask

    task automatic test_popcount();
        data_t values [4];
        values[0] = '0;
        values[1] = '1;
        values[2] = data_t'($random(seed));
        values[3] = data_t'($random(seed));
        foreach (values[i]) begin
            load_reg(4'd1, values[i]);
            send_instr(op_popcnt, 4'd2, 4'd1, 4'd0, 4'd0, '0);
            @(negedge clock);
            instr_valid = 1'b0;
            check_bit("popcnt busy high", 1'b1, busy);
            @(negedge clock);
            check_bit("popcnt busy low", 1'b0, busy);
            collect_results("popcnt");
        end
    endtask

    task automatic test_bit_ops();
        int positions [4];
        positions[0] = 0;
        positions[1] = 31;
        positions[2] = $random(seed) & 31;
        positions[3] = $random(seed) & 31;
        load_reg(4'd3, 32'd1);
        load_reg(4'd4, 32'hffff_fffe);
        load_reg(4'd9, '0);
        load_reg(4'd10, '1);
        foreach (positions[i]) begin
            load_reg(4'd1, data_t'($random(seed)));
            // Upper bits of the index register must not matter
            load_reg(4'd2, (data_t'($random(seed)) & ~32'd31) | data_t'(positions[i]));
            exec_instr(op_bext, 4'd5, 4'd1, 4'd2, 4'd0, "bext");
            exec_instr(op_bset, 4'd6, 4'd1, 4'd2, 4'd3, "bset random");
            exec_instr(op_bset, 4'd7, 4'd9, 4'd2, 4'd3, "bset to one");
            exec_instr(op_bset, 4'd8, 4'd10, 4'd2, 4'd4, "bset to zero");
        end
    endtask

    task automatic test_stream();
        for (int r = 1; r < 5; r++) begin
            load_reg(reg_addr_t'(r), data_t'($random(seed)));
        end
        send_instr(op_add, 4'd5, 4'd1, 4'd2, 4'd0, '0);
        send_instr(op_popcnt, 4'd6, 4'd3, 4'd0, 4'd0, '0);
        send_instr(op_xor, 4'd7, 4'd1, 4'd4, 4'd0, '0);
        send_instr(op_t'(6'd47), 4'd8, 4'd1, 4'd2, 4'd0, '0);
        send_instr(op_bext, 4'd9, 4'd2, 4'd3, 4'd0, '0);
        send_instr(op_sub, 4'd10, 4'd4, 4'd1, 4'd0, '0);
        send_instr(op_bset, 4'd11, 4'd3, 4'd4, 4'd1, '0);
        send_instr(op_and, 4'd12, 4'd2, 4'd3, 4'd0, '0);
        send_instr(op_popcnt, 4'd13, 4'd4, 4'd0, 4'd0, '0);
        send_instr(op_or, 4'd14, 4'd1, 4'd3, 4'd0, '0);
        stop_driving();
        collect_results("stream");
        expect_quiet("stream", 8);
    endtask

    initial begin
        seed        = 94;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr_op    = op_nop;
        instr_dest  = '0;
        instr_src_a = '0;
        instr_src_b = '0;
        instr_src_c = '0;
        instr_imm   = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        test_reset_state();
        test_logic_ops();
        test_popcount();
        test_bit_ops();
        test_stream();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== logic/fcore_slice.sv ====
/*
 * Execution slice of the control core.
 * Issue stage, register file, bit manipulation and logic units, and writeback.
 */
`timescale 1ns/100ps

module fcore_slice (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  fcore_isa_pkg::op_t       instr_op,
    input  fcore_isa_pkg::reg_addr_t instr_dest,
    input  fcore_isa_pkg::reg_addr_t instr_src_a,
    input  fcore_isa_pkg::reg_addr_t instr_src_b,
    input  fcore_isa_pkg::reg_addr_t instr_src_c,
    input  fcore_isa_pkg::data_t     instr_imm,
    output logic                     busy,
    output logic                     result_valid,
    output fcore_isa_pkg::reg_addr_t result_dest,
    output fcore_isa_pkg::data_t     result_data
);
    import fcore_isa_pkg::*;

    reg_addr_t rd_addr_a, rd_addr_b, rd_addr_c;
    data_t     rd_data_a, rd_data_b, rd_data_c;

    logic      bm_valid, lu_valid;
    op_t       issue_op;
    reg_addr_t issue_dest;
    data_t     operand_a, operand_b, operand_c, issue_imm;

    logic      bm_result_valid, lu_result_valid;
    reg_addr_t bm_result_dest, lu_result_dest;
    data_t     bm_result_data, lu_result_data;

    logic      wr_en;
    reg_addr_t wr_addr;
    data_t     wr_data;

    operand_fetch u_fetch (
        .clock, .rst_n,
        .instr_valid, .instr_op, .instr_dest,
        .instr_src_a, .instr_src_b, .instr_src_c, .instr_imm,
        .rd_data_a, .rd_data_b, .rd_data_c,
        .rd_addr_a, .rd_addr_b, .rd_addr_c,
        .busy, .bm_valid, .lu_valid,
        .issue_op, .issue_dest,
        .operand_a, .operand_b, .operand_c, .issue_imm
    );

    register_file u_regs (
        .clock, .rst_n,
        .rd_addr_a, .rd_addr_b, .rd_addr_c,
        .wr_en, .wr_addr, .wr_data,
        .rd_data_a, .rd_data_b, .rd_data_c
    );

    bitmanip_unit u_bitmanip (
        .clock, .rst_n,
        .bm_valid, .issue_op, .issue_dest,
        .operand_a, .operand_b, .operand_c,
        .bm_result_valid, .bm_result_dest, .bm_result_data
    );

    logic_unit u_logic (
        .clock, .rst_n,
        .lu_valid, .issue_op, .issue_dest,
        .operand_a, .operand_b, .issue_imm,
        .lu_result_valid, .lu_result_dest, .lu_result_data
    );

    result_writeback u_writeback (
        .clock, .rst_n,
        .bm_result_valid, .bm_result_dest, .bm_result_data,
        .lu_result_valid, .lu_result_dest, .lu_result_data,
        .wr_en, .wr_addr, .wr_data,
        .result_valid, .result_dest, .result_data
    );

endmodule

// ==== logic/result_writeback.sv ====
/*
 * Writeback stage.
 * Merges the two unit results, drives the register file write port and
 * reports each retired result one cycle later.
 */
`timescale 1ns/100ps

module result_writeback (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     bm_result_valid,
    input  fcore_isa_pkg::reg_addr_t bm_result_dest,
    input  fcore_isa_pkg::data_t     bm_result_data,
    input  logic                     lu_result_valid,
    input  fcore_isa_pkg::reg_addr_t lu_result_dest,
    input  fcore_isa_pkg::data_t     lu_result_data,
    output logic                     wr_en,
    output fcore_isa_pkg::reg_addr_t wr_addr,
    output fcore_isa_pkg::data_t     wr_data,
    output logic                     result_valid,
    output fcore_isa_pkg::reg_addr_t result_dest,
    output fcore_isa_pkg::data_t     result_data
);
    import fcore_isa_pkg::*;

    // Idle units drive zeros, so an OR picks whichever one has a result
    assign wr_en   = bm_result_valid | lu_result_valid;
    assign wr_addr = bm_result_dest | lu_result_dest;
    assign wr_data = bm_result_data | lu_result_data;

    // The register file takes the write on the same edge that loads the report
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_dest  <= '0;
            result_data  <= '0;
        end else begin
            result_valid <= wr_en;
            result_dest  <= wr_addr;
            result_data  <= wr_data;
        end
    end

    a_single_unit_result : assert property (
        @(posedge clock) disable iff (!rst_n) !(bm_result_valid && lu_result_valid)
    );

endmodule

// ==== logic/logic_unit.sv ====
/*
 * Logic and arithmetic unit.
 * Add, subtract, bitwise and, or, xor and load immediate, each registered
 * in a single cycle.
 */
`timescale 1ns/100ps

module logic_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     lu_valid,
    input  fcore_isa_pkg::op_t       issue_op,
    input  fcore_isa_pkg::reg_addr_t issue_dest,
    input  fcore_isa_pkg::data_t     operand_a,
    input  fcore_isa_pkg::data_t     operand_b,
    input  fcore_isa_pkg::data_t     issue_imm,
    output logic                     lu_result_valid,
    output fcore_isa_pkg::reg_addr_t lu_result_dest,
    output fcore_isa_pkg::data_t     lu_result_data
);
    import fcore_isa_pkg::*;

    data_t lu_value;

    // Add and sub wrap modulo 2^32
    always_comb begin
        case (issue_op)
            op_add:  lu_value = operand_a + operand_b;
            op_sub:  lu_value = operand_a - operand_b;
            op_and:  lu_value = operand_a & operand_b;
            op_or:   lu_value = operand_a | operand_b;
            op_xor:  lu_value = operand_a ^ operand_b;
            op_ldi:  lu_value = issue_imm;
            default: lu_value = '0;
        endcase
    end

    // Outputs stay at zero whenever there is no result, so writeback can OR them
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lu_result_valid <= 1'b0;
            lu_result_dest  <= '0;
            lu_result_data  <= '0;
        end else if (lu_valid) begin
            lu_result_valid <= 1'b1;
            lu_result_dest  <= issue_dest;
            lu_result_data  <= lu_value;
        end else begin
            lu_result_valid <= 1'b0;
            lu_result_dest  <= '0;
            lu_result_data  <= '0;
        end
    end

endmodule

// ==== logic/bitmanip_unit.sv ====
/*
 * Bit manipulation unit.
 * Bit extract and bit set finish in one cycle. Popcount is a two stage pipeline
 * that counts each 16-bit half first and adds the partial counts after.
 */
`timescale 1ns/100ps

module bitmanip_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     bm_valid,
    input  fcore_isa_pkg::op_t       issue_op,
    input  fcore_isa_pkg::reg_addr_t issue_dest,
    input  fcore_isa_pkg::data_t     operand_a,
    input  fcore_isa_pkg::data_t     operand_b,
    input  fcore_isa_pkg::data_t     operand_c,
    output logic                     bm_result_valid,
    output fcore_isa_pkg::reg_addr_t bm_result_dest,
    output fcore_isa_pkg::data_t     bm_result_data
);
    import fcore_isa_pkg::*;

    logic [$clog2(data_width)-1:0] bit_index;
    data_t                         bset_value;

    logic                          s1_valid;
    reg_addr_t                     s1_dest;
    logic [$clog2(data_width/2):0] partial_lo;
    logic [$clog2(data_width/2):0] partial_hi;

    // Single cycle path result (bext, bset)
    logic      sc_valid;
    reg_addr_t sc_dest;
    data_t     sc_data;

    // Popcount path result
    logic      pc_valid;
    reg_addr_t pc_dest;
    data_t     pc_data;

    function automatic logic [$clog2(data_width/2):0] count_half(
        input logic [data_width/2-1:0] half
    );
        logic [$clog2(data_width/2):0] count;
        count = '0;
        for (int i = 0; i < data_width/2; i++) begin
            count = count + half[i];
        end
        return count;
    endfunction

    assign bit_index = operand_b[$clog2(data_width)-1:0];

    always_comb begin
        bset_value            = operand_a;
        bset_value[bit_index] = operand_c[0];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sc_valid <= 1'b0;
            sc_dest  <= '0;
            sc_data  <= '0;
        end else begin
            sc_valid <= 1'b0;
            sc_dest  <= '0;
            sc_data  <= '0;
            if (bm_valid && issue_op == op_bext) begin
                sc_valid <= 1'b1;
                sc_dest  <= issue_dest;
                sc_data  <= data_t'(operand_a[bit_index]);
            end else if (bm_valid && issue_op == op_bset) begin
                sc_valid <= 1'b1;
                sc_dest  <= issue_dest;
                sc_data  <= bset_value;
            end
        end
    end

    // The first popcount stage counts each half on its own
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= bm_valid && (issue_op == op_popcnt);
        end
    end

    always_ff @(posedge clock) begin
        s1_dest    <= issue_dest;
        partial_lo <= count_half(operand_a[data_width/2-1:0]);
        partial_hi <= count_half(operand_a[data_width-1:data_width/2]);
    end

    // Second stage adds the halves; idle cycles leave the outputs at zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_valid <= 1'b0;
            pc_dest  <= '0;
            pc_data  <= '0;
        end else begin
            pc_valid <= s1_valid;
            pc_dest  <= s1_valid ? s1_dest : '0;
            pc_data  <= s1_valid ? data_t'(partial_lo) + data_t'(partial_hi) : '0;
        end
    end

    assign bm_result_valid = sc_valid | pc_valid;
    assign bm_result_dest  = sc_dest | pc_dest;
    assign bm_result_data  = sc_data | pc_data;

    // A popcount blocks the next issue slot, so no bext or bset can follow it directly
    a_popcnt_path_alone : assert property (
        @(posedge clock) disable iff (!rst_n)
        (bm_valid && issue_op == op_popcnt) |=>
            !(bm_valid && (issue_op == op_bext || issue_op == op_bset))
    );

endmodule

// ==== logic/operand_fetch.sv ====
/*
 * Issue stage of the execution slice.
 * Samples the instruction strobe, starts the operand reads and one cycle later
 * hands the instruction to the unit that owns its opcode. Raises busy for the
 * extra popcount cycle.
 */
`timescale 1ns/100ps

module operand_fetch (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  fcore_isa_pkg::op_t       instr_op,
    input  fcore_isa_pkg::reg_addr_t instr_dest,
    input  fcore_isa_pkg::reg_addr_t instr_src_a,
    input  fcore_isa_pkg::reg_addr_t instr_src_b,
    input  fcore_isa_pkg::reg_addr_t instr_src_c,
    input  fcore_isa_pkg::data_t     instr_imm,
    input  fcore_isa_pkg::data_t     rd_data_a,
    input  fcore_isa_pkg::data_t     rd_data_b,
    input  fcore_isa_pkg::data_t     rd_data_c,
    output fcore_isa_pkg::reg_addr_t rd_addr_a,
    output fcore_isa_pkg::reg_addr_t rd_addr_b,
    output fcore_isa_pkg::reg_addr_t rd_addr_c,
    output logic                     busy,
    output logic                     bm_valid,
    output logic                     lu_valid,
    output fcore_isa_pkg::op_t       issue_op,
    output fcore_isa_pkg::reg_addr_t issue_dest,
    output fcore_isa_pkg::data_t     operand_a,
    output fcore_isa_pkg::data_t     operand_b,
    output fcore_isa_pkg::data_t     operand_c,
    output fcore_isa_pkg::data_t     issue_imm
);
    import fcore_isa_pkg::*;

    logic      s0_valid;
    op_t       s0_op;
    reg_addr_t s0_dest;
    data_t     s0_imm;
    logic      s0_is_bm;
    logic      s0_is_lu;

    // The register file samples the source fields on the same edge as we do
    assign rd_addr_a = instr_src_a;
    assign rd_addr_b = instr_src_b;
    assign rd_addr_c = instr_src_c;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s0_valid <= 1'b0;
        end else begin
            s0_valid <= instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        s0_op   <= instr_op;
        s0_dest <= instr_dest;
        s0_imm  <= instr_imm;
    end

    // Route by opcode; nop and undefined codes select no unit
    always_comb begin
        s0_is_bm = 1'b0;
        s0_is_lu = 1'b0;
        case (s0_op)
            op_popcnt, op_bext, op_bset: s0_is_bm = s0_valid;
            op_add, op_sub, op_and, op_or, op_xor, op_ldi: s0_is_lu = s0_valid;
            default: begin
                s0_is_bm = 1'b0;
                s0_is_lu = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bm_valid <= 1'b0;
            lu_valid <= 1'b0;
            busy     <= 1'b0;
        end else begin
            bm_valid <= s0_is_bm;
            lu_valid <= s0_is_lu;
            // One blocked slot keeps popcount and a later op out of writeback together
            busy     <= instr_valid && (instr_op == op_popcnt);
        end
    end

    // Operands arrive from the register file one cycle after sampling
    always_ff @(posedge clock) begin
        issue_op   <= s0_op;
        issue_dest <= s0_dest;
        issue_imm  <= s0_imm;
        operand_a  <= rd_data_a;
        operand_b  <= rd_data_b;
        operand_c  <= rd_data_c;
    end

    // The sequencer has to hold off while the popcount slot is blocked
    a_no_issue_while_busy : assert property (
        @(posedge clock) disable iff (!rst_n) busy |-> !instr_valid
    );

endmodule

// ==== logic/register_file.sv ====
/*
 * General purpose register file of the execution slice.
 * Three synchronous read ports and one write port; a read on the same edge
 * as a write to that register returns the value stored before the write.
 */
`timescale 1ns/100ps

module register_file (
    input  logic                     clock,
    input  logic                     rst_n,
    input  fcore_isa_pkg::reg_addr_t rd_addr_a,
    input  fcore_isa_pkg::reg_addr_t rd_addr_b,
    input  fcore_isa_pkg::reg_addr_t rd_addr_c,
    input  logic                     wr_en,
    input  fcore_isa_pkg::reg_addr_t wr_addr,
    input  fcore_isa_pkg::data_t     wr_data,
    output fcore_isa_pkg::data_t     rd_data_a,
    output fcore_isa_pkg::data_t     rd_data_b,
    output fcore_isa_pkg::data_t     rd_data_c
);
    import fcore_isa_pkg::*;

    data_t regs [reg_count];

    // Storage is cleared at reset so every register starts at zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Registered reads see the array contents from before this edge's write
    always_ff @(posedge clock) begin
        rd_data_a <= regs[rd_addr_a];
        rd_data_b <= regs[rd_addr_b];
        rd_data_c <= regs[rd_addr_c];
    end

endmodule

// ==== logic/fcore_isa_pkg.sv ====
/*
 * Instruction set and datapath definitions for the control core execution slice.
 * Holds the register and result sizes, the register index type and the opcode map.
 */
package fcore_isa_pkg;

    // Datapath sizes
    localparam int data_width     = 32;
    localparam int reg_count      = 16;
    localparam int reg_addr_width = 4;
    localparam int opcode_width   = 6;

    typedef logic [data_width-1:0]     data_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // Opcode values not listed here are undefined and retire without a result
    typedef enum logic [opcode_width-1:0] {
        op_nop    = 6'd0,
        op_add    = 6'd1,
        op_sub    = 6'd2,
        op_popcnt = 6'd3,
        op_and    = 6'd4,
        op_bext   = 6'd5,
        op_or     = 6'd6,
        op_bset   = 6'd7,
        op_xor    = 6'd8,
        op_ldi    = 6'd9
    } op_t;

endpackage
